/* verilog.f */
+incdir+test
src/seqPkg.sv
src/scorePkg.sv
src/targetFeed.sv
src/rowZero.sv
src/smWaCell.sv
src/scoreTracker.sv
src/systolicAligner.sv
test/tbAligner.sv

/* run.sh */
#!/bin/sh
# build and run the aligner testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbAligner -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VtbAligner > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the fail line on any failed check or timeout
if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

/* test/alignRef.svh */
// reference global alignment: linear gap DP, best bottom-row score and its target index
`ifndef ALIGN_REF_SVH
`define ALIGN_REF_SVH

// largest of three candidates, earlier argument wins a tie
function automatic int max3(input int a, input int b, input int c);
    int m;
    m = a;
    if (b > m) begin
        m = b;
    end
    if (c > m) begin
        m = c;
    end
    return m;
endfunction

// base i of the packed query, base 0 in the low bits
function automatic int queryBaseAt(input logic [QUERY_W-1:0] q, input int i);
    return int'(q[i*BASE_W +: BASE_W]);
endfunction

// rows are query bases, columns are target bases
// H(0, j) = seed + j*gap, H(i, 0) = seed + i*gap
function automatic void refAlign(
    input  logic [QUERY_W-1:0] q,
    input  int                 len,
    input  int                 tgt [64],
    input  int                 n,
    input  int                 seed,
    input  int                 matchS,
    input  int                 mismatchS,
    input  int                 gapS,
    output int                 bestScore,
    output int                 bestIdx
);
    int prevRow [65];
    int curRow  [65];
    int sub;
    int i;
    int j;
    for (j = 0; j <= n; j++) begin
        prevRow[j] = seed + j * gapS;
    end
    for (i = 1; i <= len; i++) begin
        curRow[0] = seed + i * gapS;
        for (j = 1; j <= n; j++) begin
            sub = (tgt[j-1] == queryBaseAt(q, i - 1)) ? matchS : mismatchS;
            curRow[j] = max3(prevRow[j-1] + sub, prevRow[j] + gapS, curRow[j-1] + gapS);
        end
        prevRow = curRow;
    end
    // column j holds target index j-1, first maximum wins
    bestScore = prevRow[1];
    bestIdx   = 0;
    for (j = 2; j <= n; j++) begin
        if (prevRow[j] > bestScore) begin
            bestScore = prevRow[j];
            bestIdx   = j - 1;
        end
    end
endfunction

`endif

/* test/tbAligner.sv */
// testbench that checks the systolic aligner against a reference DP with random queries and targets
module tbAligner import seqPkg::*, scorePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_RUNS       = 6;
    localparam int SEED           = 32'h7202_94d5;

    logic                     clk = 1'b0;
    logic                     rst;
    scoreT                    match;
    scoreT                    mismatch;
    scoreT                    gap;
    logic [QUERY_W-1:0]       query;
    logic [MAX_QUERY_LEN-1:0] queryEn;
    logic [MAX_QUERY_LEN-1:0] queryReady;
    baseT                     targetBase;
    logic                     targetStart;
    logic                     targetLast;
    logic                     targetValid;
    scoreT                    targetScore;
    scoreT                    score;
    logic [T_POS_W-1:0]       scoreIndex;
    logic                     scoreValid;
    logic                     scoreReady;

    // scoring values as plain integers for the reference
    int matchVal;
    int mismatchVal;
    int gapVal;
    // expected results with one entry per target in flight
    int expScoreQ [$];
    int expIdxQ   [$];
    int sentCount    = 0;
    int checkedCount = 0;
    int errCount     = 0;
    // upper bound of the random scoreReady stall
    // zero accepts the result at once
    int holdMax      = 0;
    int testsRun     = 0;
    int testsFailed  = 0;
    // queryReady bits seen high since the current target started
    logic [MAX_QUERY_LEN-1:0] readySeen;

    `include "alignRef.svh"

    always #10 clk = ~clk;

    systolicAligner u_systolicAligner (
        .clk        (clk),
        .rst        (rst),
        .match      (match),
        .mismatch   (mismatch),
        .gap        (gap),
        .query      (query),
        .queryEn    (queryEn),
        .queryReady (queryReady),
        .targetBase (targetBase),
        .targetStart(targetStart),
        .targetLast (targetLast),
        .targetValid(targetValid),
        .targetScore(targetScore),
        .score      (score),
        .scoreIndex (scoreIndex),
        .scoreValid (scoreValid),
        .scoreReady (scoreReady)
    );

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    task automatic abortRun(input string why);
        $display("timeout: %s", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: FAILED, %0d errors", testsRun, name, errCount - errBefore);
        end
    endtask

    // step to the next falling edge and track which cells took their query base
    // once all of them have, the query bus is inverted so a late load shows in the score
    task automatic nextCycle(input logic [QUERY_W-1:0] q, input logic [MAX_QUERY_LEN-1:0] en);
        @(negedge clk);
        if (readySeen == '1) begin
            query   = ~q;
            queryEn = ~en;
        end
        readySeen = readySeen | queryReady;
    endtask

    // one target of n bases against a len-base query prefix
    // withGaps drops targetValid for up to two cycles before each base
    task automatic runTarget(input int len, input int n, input int seed, input bit withGaps);
        int                       tgt [64];
        logic [QUERY_W-1:0]       q;
        logic [MAX_QUERY_LEN-1:0] en;
        int                       expS;
        int                       expI;
        int                       stall;
        int                       cnt;
        for (int k = 0; k < n; k++) begin
            tgt[k] = $urandom_range(0, 3);
        end
        q  = QUERY_W'($urandom);
        en = MAX_QUERY_LEN'((1 << len) - 1);
        refAlign(q, len, tgt, n, seed, matchVal, mismatchVal, gapVal, expS, expI);
        expScoreQ.push_back(expS);
        expIdxQ.push_back(expI);
        // query and queryEn stay on the bus until every cell has taken its base
        query       = q;
        queryEn     = en;
        targetScore = scoreT'(seed);
        targetStart = 1'b1;
        @(negedge clk);
        targetStart = 1'b0;
        // first look at queryReady after the start edge
        readySeen   = queryReady;
        for (int k = 0; k < n; k++) begin
            stall = withGaps ? $urandom_range(0, 2) : 0;
            repeat (stall) begin
                targetValid = 1'b0;
                targetBase  = baseT'($urandom_range(0, 3));
                nextCycle(q, en);
            end
            targetBase  = baseT'(tgt[k][1:0]);
            targetValid = 1'b1;
            targetLast  = (k == n - 1);
            nextCycle(q, en);
        end
        targetValid = 1'b0;
        targetLast  = 1'b0;
        sentCount++;
        cnt = 0;
        while (checkedCount != sentCount && cnt < TIMEOUT_CYCLES) begin
            nextCycle(q, en);
            cnt++;
        end
        if (checkedCount != sentCount) begin
            $display("the result of target %0d was not checked in time", sentCount);
            errCount++;
        end
    endtask

    // compare one buffered result, stall it for a while, then accept it
    task automatic checkResult();
        int                 expS;
        int                 expI;
        int                 hold;
        scoreT              heldScore;
        logic [T_POS_W-1:0] heldIdx;
        expS = expScoreQ.pop_front();
        expI = expIdxQ.pop_front();
        assert (int'(score) == expS) else begin
            $display("ERROR %0t: score %0d, expected %0d", $time, score, expS);
            errCount++;
        end
        assert (int'(scoreIndex) == expI) else begin
            $display("ERROR %0t: scoreIndex %0d, expected %0d", $time, scoreIndex, expI);
            errCount++;
        end
        // buffer must not move under back-pressure
        hold      = (holdMax > 0) ? $urandom_range(1, holdMax) : 0;
        heldScore = score;
        heldIdx   = scoreIndex;
        repeat (hold) begin
            @(negedge clk);
            assert (scoreValid && score == heldScore && scoreIndex == heldIdx) else begin
                $display("ERROR %0t: result moved while stalled, valid %0b score %0d idx %0d",
                         $time, scoreValid, score, scoreIndex);
                errCount++;
            end
        end
        scoreReady = 1'b1;
        @(negedge clk);
        scoreReady = 1'b0;
        assert (!scoreValid) else begin
            $display("ERROR %0t: scoreValid still high after the handshake", $time);
            errCount++;
        end
        checkedCount++;
    endtask

    ////////////////////////////////
    // compare process
    ////////////////////////////////

    initial begin : compareProc
        int    cnt;
        string why;
        scoreReady = 1'b0;
        why        = "";
        while (why == "") begin
            cnt = 0;
            while (expScoreQ.size() == 0 && cnt < 10 * TIMEOUT_CYCLES) begin
                @(negedge clk);
                cnt++;
            end
            if (expScoreQ.size() == 0) begin
                why = "no target was sent to the DUT for too long";
            end else begin
                cnt = 0;
                while (!scoreValid && cnt < TIMEOUT_CYCLES) begin
                    @(negedge clk);
                    cnt++;
                end
                if (!scoreValid) begin
                    why = "scoreValid never rose after the last base";
                end else begin
                    checkResult();
                end
            end
        end
        abortRun(why);
    end

    ////////////////////////////////
    // stimulus
    ////////////////////////////////

    initial begin : mainProc
        int errBefore;
        int seed;
        void'($urandom(SEED));
        rst         = 1'b1;
        query       = '0;
        queryEn     = '0;
        targetBase  = BASE_A;
        targetStart = 1'b0;
        targetLast  = 1'b0;
        targetValid = 1'b0;
        targetScore = '0;
        readySeen   = '0;
        // scoring stays fixed for the whole run
        matchVal    = $urandom_range(1, 4);
        mismatchVal = -int'($urandom_range(1, 3));
        gapVal      = -int'($urandom_range(1, 3));
        match       = scoreT'(matchVal);
        mismatch    = scoreT'(mismatchVal);
        gap         = scoreT'(gapVal);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        errBefore = errCount;
        assert (!scoreValid) else begin
            $display("ERROR %0t: scoreValid high after reset", $time);
            errCount++;
        end
        assert (queryReady == '1) else begin
            $display("ERROR %0t: queryReady %b after reset", $time, queryReady);
            errCount++;
        end
        reportTest("reset state", errBefore);

        errBefore = errCount;
        for (int r = 0; r < NUM_RUNS; r++) begin
            runTarget(MAX_QUERY_LEN, $urandom_range(4, 40), 0, 1'b0);
        end
        reportTest("full query", errBefore);

        errBefore = errCount;
        for (int r = 0; r < NUM_RUNS; r++) begin
            runTarget($urandom_range(1, 7), $urandom_range(4, 40), 0, 1'b0);
        end
        reportTest("short query", errBefore);

        errBefore = errCount;
        for (int r = 0; r < NUM_RUNS; r++) begin
            runTarget($urandom_range(1, 8), $urandom_range(4, 40), 0, 1'b1);
        end
        reportTest("valid gaps", errBefore);

        errBefore = errCount;
        for (int r = 0; r < NUM_RUNS; r++) begin
            seed = int'($urandom_range(0, 100)) - 50;
            if (seed == 0) begin
                seed = -13;
            end
            runTarget($urandom_range(1, 8), $urandom_range(4, 40), seed, 1'b0);
        end
        reportTest("signed seed", errBefore);

        errBefore = errCount;
        holdMax   = 8;
        for (int r = 0; r < NUM_RUNS; r++) begin
            runTarget($urandom_range(1, 8), $urandom_range(4, 40), 0, 1'b1);
        end
        holdMax = 0;
        reportTest("back-pressure", errBefore);

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src/systolicAligner.sv */
// linear systolic array top: global alignment score of a short query against a target stream
module systolicAligner import seqPkg::*, scorePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // scoring, held stable for the whole run
    input  scoreT                    match,
    input  scoreT                    mismatch,
    input  scoreT                    gap,
    // query, zipper-loaded at each target start
    input  logic [QUERY_W-1:0]       query,
    input  logic [MAX_QUERY_LEN-1:0] queryEn,
    output logic [MAX_QUERY_LEN-1:0] queryReady,
    // target stream
    input  baseT                     targetBase,
    input  logic                     targetStart,
    input  logic                     targetLast,
    input  logic                     targetValid,
    input  scoreT                    targetScore,
    // result
    output scoreT                    score,
    output logic [T_POS_W-1:0]       scoreIndex,
    output logic                     scoreValid,
    input  logic                     scoreReady
);

    logic                     enable;
    logic [MAX_QUERY_LEN+1:0] startChain;
    logic [MAX_QUERY_LEN+1:0] lastChain;

    // cell c reads entry c and drives entry c+1
    baseT  baseChain [0:MAX_QUERY_LEN];
    scoreT hChain    [0:MAX_QUERY_LEN];

    targetFeed u_targetFeed (
        .clk        (clk),
        .rst        (rst),
        .targetBase (targetBase),
        .targetStart(targetStart),
        .targetLast (targetLast),
        .targetValid(targetValid),
        .enable     (enable),
        .baseOut    (baseChain[0]),
        .startChain (startChain),
        .lastChain  (lastChain),
        .queryReady (queryReady)
    );

    rowZero u_rowZero (
        .clk        (clk),
        .targetStart(targetStart),
        .targetScore(targetScore),
        .gap        (gap),
        .enable     (enable),
        .hRow0      (hChain[0])
    );

    ////////////////////////////////
    // cell chain
    ////////////////////////////////

    for (genvar c = 0; c < MAX_QUERY_LEN; c++) begin : genCell
        smWaCell u_smWaCell (
            .clk      (clk),
            .rst      (rst),
            .enable   (enable),
            .match    (match),
            .mismatch (mismatch),
            .gap      (gap),
            .queryBase(baseT'(query[c*BASE_W +: BASE_W])),
            .queryEnIn(queryEn[c]),
            .newTarget(startChain[c]),
            .baseIn   (baseChain[c]),
            .hIn      (hChain[c]),
            .baseOut  (baseChain[c+1]),
            .hOut     (hChain[c+1])
        );
    end

    // bottom H lines up with marker position MAX_QUERY_LEN
    scoreTracker u_scoreTracker (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .hBottom    (hChain[MAX_QUERY_LEN]),
        .startBottom(startChain[MAX_QUERY_LEN]),
        .lastBottom (lastChain[MAX_QUERY_LEN+1]),
        .score      (score),
        .scoreIndex (scoreIndex),
        .scoreValid (scoreValid),
        .scoreReady (scoreReady)
    );

endmodule

/* src/scoreTracker.sv */
// bottom-row best score search with a one-entry valid/ready result buffer
module scoreTracker import seqPkg::*, scorePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  scoreT              hBottom,
    input  logic               startBottom,
    input  logic               lastBottom,
    output scoreT              score,
    output logic [T_POS_W-1:0] scoreIndex,
    output logic               scoreValid,
    input  logic               scoreReady
);

    scoreT              best;
    logic [T_POS_W-1:0] bestIdx;
    // index of the target base whose column is at the bottom
    logic [T_POS_W-1:0] colCount;

    ////////////////////////////////
    // best score search
    ////////////////////////////////

    // start marker comes with column 0, which is skipped
    // column j then carries target index j-1
    always_ff @(posedge clk) begin
        if (rst) begin
            colCount <= '0;
        end else if (enable) begin
            if (startBottom) begin
                colCount <= '0;
            end else begin
                colCount <= colCount + 1'b1;
            end
        end
    end

    // strictly greater, so the first column reaching the best wins
    always_ff @(posedge clk) begin
        if (enable) begin
            if (startBottom) begin
                best    <= SCORE_MIN;
                bestIdx <= '0;
            end else if (hBottom > best) begin
                best    <= hBottom;
                bestIdx <= colCount;
            end
        end
    end

    ////////////////////////////////
    // result buffer
    ////////////////////////////////

    // last column was folded into best on the previous enabled edge
    always_ff @(posedge clk) begin
        if (enable && lastBottom) begin
            score      <= best;
            scoreIndex <= bestIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scoreValid <= 1'b0;
        end else if (enable && lastBottom) begin
            scoreValid <= 1'b1;
        end else if (scoreReady) begin
            scoreValid <= 1'b0;
        end
    end

endmodule

/* src/smWaCell.sv */
// systolic cell: one query base, computes one row of the global alignment matrix
module smWaCell import seqPkg::*, scorePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  enable,
    input  scoreT match,
    input  scoreT mismatch,
    input  scoreT gap,
    input  baseT  queryBase,
    input  logic  queryEnIn,
    input  logic  newTarget,
    input  baseT  baseIn,
    input  scoreT hIn,
    output baseT  baseOut,
    output scoreT hOut
);

    // query base held for the whole target
    baseT  qBase;
    // cell takes part in scoring
    logic  qEn;
    // H(i-1, j-1), previous hIn
    scoreT hDiag;

    scoreT subScore;
    scoreT termDiag;
    scoreT termUp;
    scoreT termLeft;
    scoreT hNext;

    ////////////////////////////////
    // recurrence
    ////////////////////////////////

    assign subScore = (baseIn == qBase) ? match : mismatch;

    // diagonal step, substitution score
    assign termDiag = hDiag + subScore;
    // gap in the target, from the row above
    assign termUp   = hIn + gap;
    // gap in the query, from this row's previous column
    assign termLeft = hOut + gap;

    assign hNext = scoreMax(termDiag, scoreMax(termUp, termLeft));

    always_ff @(posedge clk) begin
        if (rst) begin
            qEn <= 1'b0;
        end else if (enable && newTarget) begin
            qEn <= queryEnIn;
        end
    end

    // everything holds while the array is stalled
    always_ff @(posedge clk) begin
        if (enable) begin
            baseOut <= baseIn;
            hDiag   <= hIn;
            if (newTarget) begin
                qBase <= queryBase;
                // column 0 of this row, H(i, 0) = H(i-1, 0) + gap
                hOut  <= queryEnIn ? termUp : hIn;
            end else if (qEn) begin
                hOut  <= hNext;
            end else begin
                // unused row, one-cycle pass through keeps the chain timing
                hOut  <= hIn;
            end
        end
    end

endmodule

/* src/rowZero.sv */
// row-0 boundary generator feeding the first cell with seed plus j gaps
module rowZero import scorePkg::*; (
    input  logic  clk,
    input  logic  targetStart,
    input  scoreT targetScore,
    input  scoreT gap,
    input  logic  enable,
    output scoreT hRow0
);

    ////////////////////////////////
    // boundary H(0, j)
    ////////////////////////////////

    // seed is column 0, then one gap per column
    // cell 0 reads the seed on its start edge
    // and H(0, 1) on the first base edge
    always_ff @(posedge clk) begin
        if (targetStart) begin
            hRow0 <= targetScore;
        end else if (enable) begin
            hRow0 <= hRow0 + gap;
        end
    end

endmodule

/* src/targetFeed.sv */
// target stream control: array enable, base register and start/last marker chains
module targetFeed import seqPkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  baseT                     targetBase,
    input  logic                     targetStart,
    input  logic                     targetLast,
    input  logic                     targetValid,
    output logic                     enable,
    output baseT                     baseOut,
    output logic [MAX_QUERY_LEN+1:0] startChain,
    output logic [MAX_QUERY_LEN+1:0] lastChain,
    output logic [MAX_QUERY_LEN-1:0] queryReady
);

    // high between targetStart and the accepted last base
    logic midTarget;
    // high once no target is left in the array
    logic targetsDone;
    // last marker only counts with a valid base
    logic lastAccept;

    assign lastAccept = targetLast && targetValid;

    // base register, lines up with enable one cycle later
    always_ff @(posedge clk) begin
        baseOut <= targetBase;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            midTarget <= 1'b0;
        end else if (targetStart) begin
            midTarget <= 1'b1;
        end else if (lastAccept) begin
            midTarget <= 1'b0;
        end
    end

    // inside a target the array only steps on valid bases
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
        end else if (midTarget) begin
            enable <= targetValid;
        end else begin
            enable <= 1'b1;
        end
    end

    ////////////////////////////////
    // marker chains
    ////////////////////////////////

    // markers shift one cell per enabled cycle
    // a marker arriving while stalled waits in bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            startChain <= '0;
            lastChain  <= '0;
        end else if (enable) begin
            startChain <= {startChain[MAX_QUERY_LEN:0], targetStart};
            lastChain  <= {lastChain[MAX_QUERY_LEN:0], lastAccept};
        end else begin
            if (targetStart) begin
                startChain[0] <= 1'b1;
            end
            if (lastAccept) begin
                lastChain[0] <= 1'b1;
            end
        end
    end

    // new start has priority over a finishing target
    always_ff @(posedge clk) begin
        if (rst) begin
            targetsDone <= 1'b1;
        end else if (targetStart || (startChain != '0)) begin
            targetsDone <= 1'b0;
        end else if (lastChain[MAX_QUERY_LEN-1]) begin
            targetsDone <= 1'b1;
        end
    end

    // cell c takes its query base on the enabled edge with its start bit set
    assign queryReady = (startChain[MAX_QUERY_LEN-1:0] & {MAX_QUERY_LEN{enable}})
                      | {MAX_QUERY_LEN{targetsDone}};

endmodule

/* src/scorePkg.sv */
// scoring definitions: signed score type and the max helper used by the cells
package scorePkg;

    // signed two's complement score width
    localparam int SCORE_W = 10;

    typedef logic signed [SCORE_W-1:0] scoreT;

    // most negative score, starting point for the best-score search
    localparam scoreT SCORE_MIN = {1'b1, {(SCORE_W-1){1'b0}}};

    // signed two-input maximum
    // ties return a, so earlier terms win
    function automatic scoreT scoreMax(
        input scoreT a,
        input scoreT b
    );
        scoreT res;
        res = (b > a) ? b : a;
        return res;
    endfunction

endpackage

/* src/seqPkg.sv */
// sequence definitions: base codes, query geometry and target index width
package seqPkg;

    // two-bit nucleotide code, shared by query and target
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } baseT;

    localparam int BASE_W        = 2;
    // one systolic cell per query base
    localparam int MAX_QUERY_LEN = 8;
    // packed query bus, base 0 in the low bits
    localparam int QUERY_W       = BASE_W * MAX_QUERY_LEN;
    // targets up to 255 bases
    localparam int T_POS_W       = 8;

endpackage
